//--- design/issue_queue_pkg.sv
/*
 * Shared widths, operation encodings and stage payload structs for the
 * unified issue queue. Every design and verification file imports this
 * package with a wildcard import in its module header.
 */

package issue_queue_pkg;

    //////////////////////////////
    // widths and sizes
    //////////////////////////////
    localparam int data_w      = 32;
    localparam int tag_w       = 6;
    localparam int rob_w       = 6;
    localparam int queue_depth = 8;
    localparam int num_lanes   = 3;
    localparam int lane_w      = $clog2(num_lanes);

    // loads and stores always use this lane
    localparam logic [lane_w-1:0] lsu_lane = 2'd2;

    // risc-v major opcodes handled by the queue
    localparam logic [6:0] opc_op    = 7'b0110011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

    typedef enum logic [3:0] {
        op_none  = 4'd0,
        op_add   = 4'd1,
        op_addi  = 4'd2,
        op_lui   = 4'd3,
        op_ori   = 4'd4,
        op_xor   = 4'd5,
        op_srai  = 4'd6,
        op_lb    = 4'd7,
        op_lw    = 4'd8,
        op_sb    = 4'd9,
        op_sw    = 4'd10
    } op_e;

    //////////////////////////////
    // stage payloads
    //////////////////////////////

    // renamed instruction from rename
    typedef struct packed {
        logic [6:0]        opcode;
        logic [2:0]        funct3;
        logic [tag_w-1:0]  rd;
        logic [tag_w-1:0]  rs1_tag;
        logic              rs1_ready;
        logic [data_w-1:0] rs1_value;
        logic [tag_w-1:0]  rs2_tag;
        logic              rs2_ready;
        logic [data_w-1:0] rs2_value;
        logic [data_w-1:0] imm;
    } dispatch_t;

    // decoded instruction as held in a queue entry
    typedef struct packed {
        op_e               op;
        logic [lane_w-1:0] lane;
        logic [rob_w-1:0]  rob;
        logic [tag_w-1:0]  rd;
        logic [tag_w-1:0]  src1_tag;
        logic              src1_ready;
        logic [data_w-1:0] src1_value;
        logic [tag_w-1:0]  src2_tag;
        logic              src2_ready;
        logic [data_w-1:0] src2_value;
        logic [data_w-1:0] imm;
    } uop_t;

    // one functional unit result broadcast
    typedef struct packed {
        logic              valid;
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
    } result_bus_t;

    // operation handed to a functional unit
    typedef struct packed {
        op_e               op;
        logic [tag_w-1:0]  rd;
        logic [rob_w-1:0]  rob;
        logic [data_w-1:0] src1_value;
        logic [data_w-1:0] src2_value;
        logic [data_w-1:0] imm;
    } issue_t;

endpackage

//--- design/dispatch_stage.sv
/*
 * Dispatch stage of the issue queue. Decodes one renamed instruction per
 * cycle, assigns its ROB tag and issue lane, and holds the result in a
 * single skid register until the entry array accepts it.
 */

`timescale 1ns/1ns

module dispatch_stage
    import issue_queue_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      in_valid,
    output logic      in_ready,
    input  dispatch_t in_instr,
    output logic      alloc_valid,
    input  logic      alloc_ready,
    output uop_t      alloc_uop
);

    op_e              dec_op;
    uop_t             dec_uop;
    logic             is_mem;
    logic             is_alu;
    logic             accept;
    logic             rr_lane;
    logic [rob_w-1:0] rob_next;

    //////////////////////////////
    // decode
    //////////////////////////////
    always_comb begin
        dec_op = op_none;
        case (in_instr.opcode)
            opc_op: begin
                case (in_instr.funct3)
                    3'b000:  dec_op = op_add;
                    3'b100:  dec_op = op_xor;
                    default: dec_op = op_none;
                endcase
            end
            opc_imm: begin
                case (in_instr.funct3)
                    3'b000:  dec_op = op_addi;
                    3'b101:  dec_op = op_srai;
                    3'b110:  dec_op = op_ori;
                    default: dec_op = op_none;
                endcase
            end
            opc_lui: dec_op = op_lui;
            opc_load: begin
                case (in_instr.funct3)
                    3'b000:  dec_op = op_lb;
                    3'b010:  dec_op = op_lw;
                    default: dec_op = op_none;
                endcase
            end
            opc_store: begin
                case (in_instr.funct3)
                    3'b000:  dec_op = op_sb;
                    3'b010:  dec_op = op_sw;
                    default: dec_op = op_none;
                endcase
            end
            default: dec_op = op_none;
        endcase
    end

    always_comb begin
        is_mem = dec_op inside {op_lb, op_lw, op_sb, op_sw};
        is_alu = !is_mem && (dec_op != op_none);

        dec_uop.op         = dec_op;
        dec_uop.rob        = rob_next;
        dec_uop.rd         = in_instr.rd;
        dec_uop.src1_tag   = in_instr.rs1_tag;
        dec_uop.src1_ready = in_instr.rs1_ready;
        dec_uop.src1_value = in_instr.rs1_value;
        dec_uop.src2_tag   = in_instr.rs2_tag;
        dec_uop.src2_ready = in_instr.rs2_ready;
        dec_uop.src2_value = in_instr.rs2_value;
        dec_uop.imm        = in_instr.imm;

        // lui has no register sources, lw no second one
        if (dec_op == op_lui) begin
            dec_uop.src1_ready = 1'b1;
            dec_uop.src1_value = '0;
        end
        if ((dec_op == op_lui) || (dec_op == op_lw)) begin
            dec_uop.src2_ready = 1'b1;
            dec_uop.src2_value = '0;
        end

        if (is_mem) begin
            dec_uop.lane = lsu_lane;
        end else if (is_alu) begin
            dec_uop.lane = {1'b0, rr_lane};
        end else begin
            dec_uop.lane = '0;
        end
    end

    // register is free when empty or draining this cycle
    assign in_ready = !alloc_valid || alloc_ready;
    assign accept   = in_valid && in_ready;

    //////////////////////////////
    // skid register and counters
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            alloc_valid <= 1'b0;
            rr_lane     <= 1'b0;
            rob_next    <= '0;
        end else begin
            if (accept) begin
                alloc_valid <= 1'b1;
                rob_next    <= rob_next + 1'b1;
                if (is_alu) begin
                    rr_lane <= !rr_lane;
                end
            end else if (alloc_ready) begin
                alloc_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alloc_uop <= dec_uop;
        end
    end

endmodule

//--- design/issue_queue_entries.sv
/*
 * Entry array of the issue queue. Writes each allocated uop into the
 * lowest free slot, snoops the result buses to wake waiting sources, and
 * frees entries on the release strobes from the select stage.
 */

`timescale 1ns/1ns

module issue_queue_entries
    import issue_queue_pkg::*;
(
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                alloc_valid,
    output logic                                alloc_ready,
    input  uop_t                                alloc_uop,
    input  result_bus_t [num_lanes-1:0]         result_bus,
    output uop_t        [queue_depth-1:0]       entry_uop,
    output logic        [queue_depth-1:0]       entry_ready,
    input  logic        [queue_depth-1:0]       release_entry
);

    logic [queue_depth-1:0] entry_valid;
    logic [queue_depth-1:0] alloc_sel;
    logic                   alloc_fire;

    // applies this cycle's broadcasts to one uop
    function automatic uop_t wake(uop_t u, result_bus_t [num_lanes-1:0] bus);
        uop_t w;
        w = u;
        // walk from the last bus down so bus 0 has the final say
        for (int b = num_lanes - 1; b >= 0; b--) begin
            if (!u.src1_ready && bus[b].valid && (bus[b].tag == u.src1_tag)) begin
                w.src1_ready = 1'b1;
                w.src1_value = bus[b].value;
            end
            if (!u.src2_ready && bus[b].valid && (bus[b].tag == u.src2_tag)) begin
                w.src2_ready = 1'b1;
                w.src2_value = bus[b].value;
            end
        end
        return w;
    endfunction

    //////////////////////////////
    // allocation
    //////////////////////////////
    assign alloc_ready = !(&entry_valid);
    assign alloc_fire  = alloc_valid && alloc_ready;

    // one-hot pick of the lowest free slot
    always_comb begin
        logic taken;
        taken     = 1'b0;
        alloc_sel = '0;
        for (int i = 0; i < queue_depth; i++) begin
            if (!entry_valid[i] && !taken) begin
                alloc_sel[i] = 1'b1;
                taken        = 1'b1;
            end
        end
    end

    //////////////////////////////
    // entry state
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < queue_depth; i++) begin
                if (alloc_fire && alloc_sel[i]) begin
                    entry_valid[i] <= 1'b1;
                end else if (release_entry[i]) begin
                    entry_valid[i] <= 1'b0;
                end
            end
        end
    end

    // payload, woken in place while waiting
    always_ff @(posedge clk) begin
        for (int i = 0; i < queue_depth; i++) begin
            if (alloc_fire && alloc_sel[i]) begin
                entry_uop[i] <= wake(alloc_uop, result_bus);
            end else if (entry_valid[i]) begin
                entry_uop[i] <= wake(entry_uop[i], result_bus);
            end
        end
    end

    // ready mask follows the registered source flags
    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            entry_ready[i] = entry_valid[i]
                           && entry_uop[i].src1_ready
                           && entry_uop[i].src2_ready;
        end
    end

endmodule

//--- design/issue_select.sv
/*
 * Select stage of the issue queue. For every lane a lowest-index picker
 * chooses one ready entry, copies it into that lane's issue register and
 * releases it. A lane register holds while its functional unit stalls.
 */

`timescale 1ns/1ns

module issue_select
    import issue_queue_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstn,
    input  uop_t   [queue_depth-1:0]      entry_uop,
    input  logic   [queue_depth-1:0]      entry_ready,
    output logic   [queue_depth-1:0]      release_entry,
    output logic   [num_lanes-1:0]        issue_valid,
    input  logic   [num_lanes-1:0]        issue_ready,
    output issue_t [num_lanes-1:0]        issue_uop
);

    logic   [num_lanes-1:0] lane_load;
    logic   [num_lanes-1:0] lane_hit;
    issue_t [num_lanes-1:0] lane_next;

    // keeps only the fields a functional unit needs
    function automatic issue_t to_issue(uop_t u);
        issue_t t;
        t.op         = u.op;
        t.rd         = u.rd;
        t.rob        = u.rob;
        t.src1_value = u.src1_value;
        t.src2_value = u.src2_value;
        t.imm        = u.imm;
        return t;
    endfunction

    //////////////////////////////
    // per-lane pickers
    //////////////////////////////
    always_comb begin
        release_entry = '0;
        lane_hit      = '0;
        lane_next     = '0;
        for (int l = 0; l < num_lanes; l++) begin
            // lane register empty or leaving this cycle
            lane_load[l] = !issue_valid[l] || issue_ready[l];
            for (int i = 0; i < queue_depth; i++) begin
                if (lane_load[l] && !lane_hit[l] && entry_ready[i]
                    && (entry_uop[i].lane == lane_w'(l))) begin
                    lane_hit[l]      = 1'b1;
                    release_entry[i] = 1'b1;
                    lane_next[l]     = to_issue(entry_uop[i]);
                end
            end
        end
    end

    //////////////////////////////
    // issue registers
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_valid <= '0;
        end else begin
            for (int l = 0; l < num_lanes; l++) begin
                if (lane_load[l]) begin
                    issue_valid[l] <= lane_hit[l];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < num_lanes; l++) begin
            if (lane_hit[l]) begin
                issue_uop[l] <= lane_next[l];
            end
        end
    end

endmodule

//--- design/issue_queue_top.sv
/*
 * Top level of the unified issue queue. Chains dispatch, the entry array
 * and the per-lane select stage between rename and three functional units.
 */

`timescale 1ns/1ns

module issue_queue_top
    import issue_queue_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  dispatch_t                     in_instr,
    input  result_bus_t [num_lanes-1:0]   result_bus,
    output logic        [num_lanes-1:0]   issue_valid,
    input  logic        [num_lanes-1:0]   issue_ready,
    output issue_t      [num_lanes-1:0]   issue_uop
);

    logic                   alloc_valid;
    logic                   alloc_ready;
    uop_t                   alloc_uop;
    uop_t [queue_depth-1:0] entry_uop;
    logic [queue_depth-1:0] entry_ready;
    logic [queue_depth-1:0] release_entry;

    dispatch_stage dispatch_i (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_uop   (alloc_uop)
    );

    issue_queue_entries entries_i (
        .clk           (clk),
        .rstn          (rstn),
        .alloc_valid   (alloc_valid),
        .alloc_ready   (alloc_ready),
        .alloc_uop     (alloc_uop),
        .result_bus    (result_bus),
        .entry_uop     (entry_uop),
        .entry_ready   (entry_ready),
        .release_entry (release_entry)
    );

    issue_select select_i (
        .clk           (clk),
        .rstn          (rstn),
        .entry_uop     (entry_uop),
        .entry_ready   (entry_ready),
        .release_entry (release_entry),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_uop     (issue_uop)
    );

endmodule

//--- verification/issue_queue_properties.sv
/*
 * Concurrent assertions for the issue queue, bound into issue_queue_top.
 * Covers valid/ready stability on the input and every lane, the lane
 * routing of memory ops and the meaning of a low in_ready.
 */

`timescale 1ns/1ns

module issue_queue_properties
    import issue_queue_pkg::*;
(
    input logic                          clk,
    input logic                          rstn,
    input logic                          in_valid,
    input logic                          in_ready,
    input dispatch_t                     in_instr,
    input logic        [num_lanes-1:0]   issue_valid,
    input logic        [num_lanes-1:0]   issue_ready,
    input issue_t      [num_lanes-1:0]   issue_uop,
    input logic        [queue_depth-1:0] entry_valid
);

    int assert_fails = 0;

    function automatic logic is_mem_op(op_e op);
        return op inside {op_lb, op_lw, op_sb, op_sw};
    endfunction

    a_in_hold: assert property (@(posedge clk) disable iff (!rstn)
        in_valid && !in_ready |=> in_valid && $stable(in_instr))
    else begin
        assert_fails++;
        $error("input instruction changed before it was accepted");
    end

    // in_ready only drops with the entry array full
    a_in_ready_full: assert property (@(posedge clk) disable iff (!rstn)
        !in_ready |-> &entry_valid)
    else begin
        assert_fails++;
        $error("in_ready low while a queue entry is free");
    end

    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        a_issue_hold: assert property (@(posedge clk) disable iff (!rstn)
            issue_valid[l] && !issue_ready[l] |=> issue_valid[l] && $stable(issue_uop[l]))
        else begin
            assert_fails++;
            $error("lane %0d output changed while stalled", l);
        end

        if (l == lsu_lane) begin : g_lsu
            a_mem_only: assert property (@(posedge clk) disable iff (!rstn)
                issue_valid[l] |-> is_mem_op(issue_uop[l].op))
            else begin
                assert_fails++;
                $error("non-memory op on lane %0d", l);
            end
        end else begin : g_alu
            a_no_mem: assert property (@(posedge clk) disable iff (!rstn)
                issue_valid[l] |-> !is_mem_op(issue_uop[l].op))
            else begin
                assert_fails++;
                $error("memory op on lane %0d", l);
            end
        end
    end

endmodule

bind issue_queue_top issue_queue_properties props_i (
    .clk         (clk),
    .rstn        (rstn),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_instr    (in_instr),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_uop   (issue_uop),
    .entry_valid (entries_i.entry_valid)
);

//--- verification/issue_queue_tb.sv
/*
 * Directed testbench for the unified issue queue. Drives renamed
 * instructions and result buses, collects every issued op per lane and
 * compares against a reference model of decode, routing and wake-up.
 */

`timescale 1ns/1ns

module issue_queue_tb
    import issue_queue_pkg::*;
();

    logic                          clk;
    logic                          rstn;
    logic                          in_valid;
    logic                          in_ready;
    dispatch_t                     in_instr;
    result_bus_t [num_lanes-1:0]   result_bus;
    logic        [num_lanes-1:0]   issue_valid;
    logic        [num_lanes-1:0]   issue_ready;
    issue_t      [num_lanes-1:0]   issue_uop;

    // model state
    logic [31:0]      rng = 32'h100e_dfff;
    logic [rob_w-1:0] rob_cnt = '0;
    logic             rr_bit = 1'b0;
    issue_t           exp_q [num_lanes][$];
    issue_t           got_q [num_lanes][$];
    int               error_count = 0;
    int               check_count = 0;
    int               cycle_count = 0;

    issue_queue_top dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .result_bus  (result_bus),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_count++;

    initial begin
        wait (cycle_count == 2000);
        $display("timeout after %0d cycles, expected issues never arrived", cycle_count);
        $display("Testbench failed");
        $finish;
    end

    // outputs are stable mid-cycle, the transfer happens at the next edge
    always @(negedge clk) begin
        for (int l = 0; l < num_lanes; l++) begin
            if (rstn && issue_valid[l] && issue_ready[l]) begin
                got_q[l].push_back(issue_uop[l]);
            end
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic op_e decode_op(logic [6:0] opcode, logic [2:0] funct3);
        case ({opcode, funct3})
            {opc_op, 3'b000}:    return op_add;
            {opc_op, 3'b100}:    return op_xor;
            {opc_imm, 3'b000}:   return op_addi;
            {opc_imm, 3'b101}:   return op_srai;
            {opc_imm, 3'b110}:   return op_ori;
            {opc_load, 3'b000}:  return op_lb;
            {opc_load, 3'b010}:  return op_lw;
            {opc_store, 3'b000}: return op_sb;
            {opc_store, 3'b010}: return op_sw;
            default:             return (opcode == opc_lui) ? op_lui : op_none;
        endcase
    endfunction

    // six alu encodings in turn
    function automatic logic [9:0] alu_encoding(int k);
        case (k % 6)
            0:       return {opc_op, 3'b000};
            1:       return {opc_op, 3'b100};
            2:       return {opc_imm, 3'b000};
            3:       return {opc_imm, 3'b101};
            4:       return {opc_imm, 3'b110};
            default: return {opc_lui, 3'b011};
        endcase
    endfunction

    function automatic dispatch_t make_instr(logic [9:0] enc, logic [tag_w-1:0] t1, logic r1,
                                             logic [tag_w-1:0] t2, logic r2);
        dispatch_t d;
        d.opcode    = enc[9:3];
        d.funct3    = enc[2:0];
        d.rd        = tag_w'(xorshift32());
        d.rs1_tag   = t1;
        d.rs1_ready = r1;
        d.rs1_value = xorshift32();
        d.rs2_tag   = t2;
        d.rs2_ready = r2;
        d.rs2_value = xorshift32();
        d.imm       = xorshift32();
        return d;
    endfunction

    function automatic result_bus_t bus(logic [tag_w-1:0] tag, logic [data_w-1:0] value);
        result_bus_t b;
        b.valid = 1'b1;
        b.tag   = tag;
        b.value = value;
        return b;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // w1 and w2 are the values later broadcast for sources that wait
    task automatic expect_issue(input dispatch_t d, input logic [31:0] w1,
                                input logic [31:0] w2);
        issue_t e;
        int     lane;
        e.op         = decode_op(d.opcode, d.funct3);
        e.rd         = d.rd;
        e.rob        = rob_cnt;
        e.imm        = d.imm;
        e.src1_value = d.rs1_ready ? d.rs1_value : w1;
        e.src2_value = d.rs2_ready ? d.rs2_value : w2;
        rob_cnt      = rob_cnt + 1'b1;
        if (e.op == op_lui) begin
            e.src1_value = '0;
            e.src2_value = '0;
        end
        if (e.op == op_lw) begin
            e.src2_value = '0;
        end
        if (e.op inside {op_lb, op_lw, op_sb, op_sw}) begin
            lane = 2;
        end else if (e.op == op_none) begin
            lane = 0;
        end else begin
            lane   = rr_bit;
            rr_bit = !rr_bit;
        end
        exp_q[lane].push_back(e);
    endtask

    task automatic send(input dispatch_t d, input logic [31:0] w1, input logic [31:0] w2);
        in_instr = d;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #10;
        in_valid = 1'b0;
        expect_issue(d, w1, w2);
    endtask

    task automatic drive_buses(input result_bus_t b0, input result_bus_t b1,
                               input result_bus_t b2);
        result_bus[0] = b0;
        result_bus[1] = b1;
        result_bus[2] = b2;
        @(posedge clk);
        #10;
        result_bus = '0;
    endtask

    task automatic expect_no_issue(input string name);
        check_count++;
        if (got_q[0].size() + got_q[1].size() + got_q[2].size() != 0) begin
            report_error($sformatf("%s: op issued before its sources were woken", name));
        end
    endtask

    // waits for every expected op, then matches them per lane
    task automatic collect_and_compare(input string name, input bit ordered);
        issue_t want;
        int     idx;
        while (got_q[0].size() < exp_q[0].size() || got_q[1].size() < exp_q[1].size()
               || got_q[2].size() < exp_q[2].size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #10;
        for (int l = 0; l < num_lanes; l++) begin
            check_count++;
            if (got_q[l].size() != exp_q[l].size()) begin
                report_error($sformatf("%s: lane %0d issued %0d ops, expected %0d",
                             name, l, got_q[l].size(), exp_q[l].size()));
            end
            while (exp_q[l].size() > 0) begin
                want = exp_q[l].pop_front();
                idx  = -1;
                for (int i = 0; i < got_q[l].size(); i++) begin
                    if (idx < 0 && got_q[l][i] == want) idx = i;
                end
                check_count++;
                if (idx < 0 || (ordered && idx != 0)) begin
                    report_error($sformatf("%s: lane %0d op %s rob %0d missing or out of order",
                                 name, l, want.op.name(), want.rob));
                    if (ordered && got_q[l].size() > 0) void'(got_q[l].pop_front());
                end else begin
                    got_q[l].delete(idx);
                end
            end
            got_q[l].delete();
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_routing();
        for (int k = 0; k < 10; k++) begin
            send(make_instr(alu_encoding(k), tag_w'(xorshift32()), 1'b1,
                            tag_w'(xorshift32()), 1'b1), '0, '0);
        end
        collect_and_compare("routing", 1'b1);
    endtask

    task automatic test_memory();
        logic [31:0] v [7];
        for (int i = 0; i < 7; i++) v[i] = xorshift32();
        send(make_instr({opc_load, 3'b000}, 6'd10, 1'b0, 6'd11, 1'b0), v[0], v[1]);
        send(make_instr({opc_load, 3'b010}, 6'd12, 1'b0, 6'd20, 1'b0), v[2], '0);
        send(make_instr({opc_store, 3'b000}, 6'd13, 1'b0, 6'd14, 1'b0), v[3], v[4]);
        send(make_instr({opc_store, 3'b010}, 6'd15, 1'b0, 6'd16, 1'b0), v[5], v[6]);
        send(make_instr({opc_lui, 3'b000}, 6'd17, 1'b0, 6'd18, 1'b0), '0, '0);
        idle(6);
        // only the lui may leave without bus activity
        check_count++;
        if (got_q[2].size() != 0 || got_q[0].size() + got_q[1].size() != 1) begin
            report_error("memory: lui did not issue alone before wake-up");
        end
        drive_buses(bus(6'd10, v[0]), bus(6'd11, v[1]), '0);
        idle(3);
        drive_buses('0, '0, bus(6'd12, v[2]));
        idle(3);
        drive_buses(bus(6'd13, v[3]), '0, bus(6'd14, v[4]));
        idle(3);
        drive_buses('0, bus(6'd15, v[5]), bus(6'd16, v[6]));
        collect_and_compare("memory", 1'b1);
    endtask

    task automatic test_wakeup();
        logic [31:0] v5;
        logic [31:0] v9_bus0;
        logic [31:0] v9_bus1;
        v5      = xorshift32();
        v9_bus0 = xorshift32();
        v9_bus1 = xorshift32();
        send(make_instr({opc_op, 3'b000}, 6'd5, 1'b0, 6'd9, 1'b0), v5, v9_bus0);
        idle(5);
        expect_no_issue("wakeup, no bus");
        drive_buses('0, '0, bus(6'd5, v5));
        idle(5);
        expect_no_issue("wakeup, one source");
        // same tag on two buses, bus 0 must win
        drive_buses(bus(6'd9, v9_bus0), bus(6'd9, v9_bus1), '0);
        collect_and_compare("wakeup", 1'b1);
    endtask

    task automatic test_backpressure();
        issue_t held;
        issue_ready[0] = 1'b0;
        send(make_instr(alu_encoding(0), 6'd1, 1'b1, 6'd2, 1'b1), '0, '0);
        send(make_instr(alu_encoding(1), 6'd3, 1'b1, 6'd4, 1'b1), '0, '0);
        send(make_instr({opc_load, 3'b010}, 6'd5, 1'b1, 6'd6, 1'b1), '0, '0);
        send(make_instr(alu_encoding(2), 6'd7, 1'b1, 6'd8, 1'b1), '0, '0);
        send(make_instr(alu_encoding(4), 6'd9, 1'b1, 6'd10, 1'b1), '0, '0);
        send(make_instr({opc_store, 3'b000}, 6'd11, 1'b1, 6'd12, 1'b1), '0, '0);
        idle(6);
        held = issue_uop[0];
        for (int i = 0; i < 5; i++) begin
            check_count++;
            if (!issue_valid[0] || issue_uop[0] != held) begin
                report_error("backpressure: stalled lane 0 output did not hold");
            end
            idle(1);
        end
        check_count++;
        if (got_q[0].size() != 0 || got_q[1].size() != exp_q[1].size()
            || got_q[2].size() != exp_q[2].size()) begin
            report_error("backpressure: lanes 1 and 2 did not drain past stalled lane 0");
        end
        issue_ready[0] = 1'b1;
        collect_and_compare("backpressure", 1'b1);
    endtask

    task automatic test_full_queue();
        int k;
        k = 0;
        // run the rob counter up close to its wrap point
        while (rob_cnt != 6'd58) begin
            send(make_instr(alu_encoding(k), 6'd0, 1'b1, 6'd0, 1'b1), '0, '0);
            k++;
        end
        collect_and_compare("full queue, fill", 1'b1);
        issue_ready = '0;
        for (int i = 0; i < 11; i++) begin
            send(make_instr(alu_encoding(i), 6'd0, 1'b1, 6'd0, 1'b1), '0, '0);
        end
        idle(3);
        check_count++;
        if (in_ready) begin
            report_error("full queue: in_ready high with entries and lane registers full");
        end
        issue_ready = '1;
        collect_and_compare("full queue", 1'b0);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        rstn        = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        result_bus  = '0;
        issue_ready = '1;
        repeat (10) @(posedge clk);
        #10;
        rstn = 1'b1;
        idle(2);
        check_count++;
        if (!in_ready || issue_valid != '0) begin
            report_error("outputs not idle after reset");
        end

        test_routing();
        test_memory();
        test_wakeup();
        test_backpressure();
        test_full_queue();

        error_count += dut_i.props_i.assert_fails;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut_i.props_i.assert_fails);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- issue_queue.f
design/issue_queue_pkg.sv
design/dispatch_stage.sv
design/issue_queue_entries.sv
design/issue_select.sv
design/issue_queue_top.sv
verification/issue_queue_properties.sv
verification/issue_queue_tb.sv

//--- Bender.yml
package:
  name: issue_queue

sources:
  - files:
      - design/issue_queue_pkg.sv
      - design/dispatch_stage.sv
      - design/issue_queue_entries.sv
      - design/issue_select.sv
      - design/issue_queue_top.sv
  - target: test
    files:
      - verification/issue_queue_properties.sv
      - verification/issue_queue_tb.sv
